// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module alu import riscvIsaPkg::*; (
    input  aluFuncE                func,
    input  logic [`RISCV_XLEN-1:0] a,
    input  logic [`RISCV_XLEN-1:0] b,
    output logic [`RISCV_XLEN-1:0] result,
    output logic                   eq,
    output logic                   lt,
    output logic                   ltu
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // branch flags, valid whatever func is
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (func)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(`RISCV_XLEN-1){1'b0}}, lt};
            ALU_SLTU:   result = {{(`RISCV_XLEN-1){1'b0}}, ltu};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module loadStoreUnit import riscvIsaPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    memReqIf.responder             mem,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [`RISCV_XLEN-1:0] wbAdr,
    output logic [`RISCV_XLEN-1:0] wbDatOut,
    output logic [3:0]             wbSel,
    input  logic [`RISCV_XLEN-1:0] wbDatIn,
    input  logic                   wbAck
);

    logic                   ackSeen;
    logic [1:0]             offset;
    logic [`RISCV_XLEN-1:0] loadShift;

    // one idle cycle between two back-to-back transfers
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ackSeen <= 1'b0;
        end else begin
            ackSeen <= wbStb && wbAck;
        end
    end

    assign offset = mem.addr[1:0];

    assign wbCyc = mem.req && !ackSeen;
    assign wbStb = mem.req && !ackSeen;
    assign wbWe  = wbStb && mem.write;
    assign wbAdr = {mem.addr[`RISCV_XLEN-1:2], 2'b00};

    // byte lanes and replicated store data
    always_comb begin
        case (mem.width)
            MEM_BYTE: begin
                wbSel    = 4'b0001 << offset;
                wbDatOut = {4{mem.wdata[7:0]}};
            end
            MEM_HALF: begin
                wbSel    = offset[1] ? 4'b1100 : 4'b0011;
                wbDatOut = {2{mem.wdata[15:0]}};
            end
            default: begin
                wbSel    = 4'b1111;
                wbDatOut = mem.wdata;
            end
        endcase
    end

    // selected lane moved down to bit 0, then extended
    assign loadShift = wbDatIn >> {offset, 3'b000};

    always_comb begin
        case (mem.width)
            MEM_BYTE: mem.rdata = {{24{!mem.unsignedLoad && loadShift[7]}}, loadShift[7:0]};
            MEM_HALF: mem.rdata = {{16{!mem.unsignedLoad && loadShift[15]}}, loadShift[15:0]};
            default:  mem.rdata = wbDatIn;
        endcase
    end

    assign mem.done = wbStb && wbAck;

    // the datapath must hold the request while the slave stalls
    stableWhileWaiting: assert property (@(posedge clk) disable iff (!rstN)
        (wbStb && !wbAck) |=> wbStb && $stable(wbAdr) && $stable(wbSel) && $stable(wbDatOut));

endmodule

`default_nettype wire

// ==== hdl/memReqIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

interface memReqIf import riscvIsaPkg::*; ();

    logic                   req;
    logic                   write;
    logic                   unsignedLoad;
    memWidthE               width;
    logic [`RISCV_XLEN-1:0] addr;
    logic [`RISCV_XLEN-1:0] wdata;
    // load data already extended to full width
    logic [`RISCV_XLEN-1:0] rdata;
    logic                   done;

    modport requester (output req, write, unsignedLoad, width, addr, wdata,
                       input rdata, done);
    modport responder (input req, write, unsignedLoad, width, addr, wdata,
                       output rdata, done);

endinterface

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module regFile #(
    parameter int ADDR_W = $clog2(`RISCV_REG_COUNT)
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [ADDR_W-1:0]      raddr1,
    input  logic [ADDR_W-1:0]      raddr2,
    input  logic [ADDR_W-1:0]      waddr,
    input  logic [`RISCV_XLEN-1:0] wdata,
    input  logic                   wen,
    output logic [`RISCV_XLEN-1:0] rdata1,
    output logic [`RISCV_XLEN-1:0] rdata2
);

    logic [`RISCV_XLEN-1:0] regs [`RISCV_REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // x0 must stay zero across every write the core issues
    x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
        ((raddr1 == '0) |-> (rdata1 == '0)) and ((raddr2 == '0) |-> (rdata2 == '0)));

endmodule

`default_nettype wire

// ==== hdl/riscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module riscvCore (
    input  logic                   clk,
    input  logic                   rstN,
    // instruction fetch, answered in the same cycle
    output logic [`RISCV_XLEN-1:0] imemAddr,
    input  logic [31:0]            imemData,
    // Wishbone classic data master
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [`RISCV_XLEN-1:0] wbAdr,
    output logic [`RISCV_XLEN-1:0] wbDatOut,
    output logic [3:0]             wbSel,
    input  logic [`RISCV_XLEN-1:0] wbDatIn,
    input  logic                   wbAck
);

    memReqIf memBus ();

    riscvDatapath u_datapath (
        .clk(clk),
        .rstN(rstN),
        .pc(imemAddr),
        .instruction(imemData),
        .mem(memBus.requester)
    );

    loadStoreUnit u_loadStoreUnit (
        .clk(clk),
        .rstN(rstN),
        .mem(memBus.responder),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatOut(wbDatOut),
        .wbSel(wbSel),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck)
    );

endmodule

`default_nettype wire

// ==== hdl/riscvCtrlPkg.sv ====
`default_nettype none

package riscvCtrlPkg;

    // next pc source
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pcSelE;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1SelE;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2SelE;

    // register writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4
    } wbSelE;

endpackage

`default_nettype wire

// ==== hdl/riscvDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module riscvDatapath import riscvIsaPkg::*, riscvCtrlPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    output logic [`RISCV_XLEN-1:0] pc,
    input  logic [31:0]            instruction,
    memReqIf.requester             mem
);

    pcSelE                  pcSel;
    op1SelE                 op1Sel;
    op2SelE                 op2Sel;
    wbSelE                  wbSel;
    aluFuncE                aluFunc;
    memWidthE               memWidth;
    logic                   branchTaken, regWrite, memReq, memWrite, memUnsigned;
    logic                   eq, lt, ltu, advance;
    logic [`RISCV_XLEN-1:0] imm, rs1, rs2, opA, opB, aluResult, wbData;
    logic [`RISCV_XLEN-1:0] pcPlus4, pcPlusImm, nextPc;

    riscvDecoder u_decoder (
        .instruction(instruction),
        .eq(eq),
        .lt(lt),
        .ltu(ltu),
        .branchTaken(branchTaken),
        .pcSel(pcSel),
        .op1Sel(op1Sel),
        .op2Sel(op2Sel),
        .wbSel(wbSel),
        .aluFunc(aluFunc),
        .regWrite(regWrite),
        .memReq(memReq),
        .memWrite(memWrite),
        .memUnsigned(memUnsigned),
        .memWidth(memWidth),
        .imm(imm)
    );

    regFile u_regFile (
        .clk(clk),
        .rstN(rstN),
        .raddr1(instruction[19:15]),
        .raddr2(instruction[24:20]),
        .waddr(instruction[11:7]),
        .wdata(wbData),
        .wen(regWrite && advance),
        .rdata1(rs1),
        .rdata2(rs2)
    );

    always_comb begin
        case (op1Sel)
            OP1_PC:   opA = pc;
            OP1_ZERO: opA = '0;
            default:  opA = rs1;
        endcase
    end

    assign opB = (op2Sel == OP2_IMM) ? imm : rs2;

    alu u_alu (
        .func(aluFunc),
        .a(opA),
        .b(opB),
        .result(aluResult),
        .eq(eq),
        .lt(lt),
        .ltu(ltu)
    );

    // load/store request, address from the ALU
    assign mem.req          = memReq;
    assign mem.write        = memWrite;
    assign mem.unsignedLoad = memUnsigned;
    assign mem.width        = memWidth;
    assign mem.addr         = aluResult;
    assign mem.wdata        = rs2;

    // stall while a memory access is outstanding
    assign advance = !memReq || mem.done;

    always_comb begin
        case (wbSel)
            WB_MEM:      wbData = mem.rdata;
            WB_PC_PLUS4: wbData = pcPlus4;
            default:     wbData = aluResult;
        endcase
    end

    assign pcPlus4   = pc + 32'd4;
    // shared by branch and JAL targets
    assign pcPlusImm = pc + imm;

    always_comb begin
        case (pcSel)
            PC_BRANCH: nextPc = branchTaken ? pcPlusImm : pcPlus4;
            PC_JAL:    nextPc = pcPlusImm;
            PC_JALR:   nextPc = {aluResult[`RISCV_XLEN-1:1], 1'b0};
            default:   nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RISCV_RESET_PC;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

    pcWordAligned: assert property (@(posedge clk) disable iff (!rstN)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/riscvDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module riscvDecoder import riscvIsaPkg::*, riscvCtrlPkg::*; (
    input  logic [31:0]            instruction,
    input  logic                   eq,
    input  logic                   lt,
    input  logic                   ltu,
    output logic                   branchTaken,
    output pcSelE                  pcSel,
    output op1SelE                 op1Sel,
    output op2SelE                 op2Sel,
    output wbSelE                  wbSel,
    output aluFuncE                aluFunc,
    output logic                   regWrite,
    output logic                   memReq,
    output logic                   memWrite,
    output logic                   memUnsigned,
    output memWidthE               memWidth,
    output logic [`RISCV_XLEN-1:0] imm
);

    opcodeE      opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    logic [31:0] immI, immS, immB, immU, immJ;

    // funct3 and funct7 bit 30 to ALU operation
    function automatic aluFuncE aluFromFunct(input logic [2:0] f3, input logic alt,
                                             input logic isReg);
        aluFuncE f;
        case (f3)
            3'b000: begin
                if (isReg && alt) f = ALU_SUB;
                else              f = ALU_ADD;
            end
            3'b001: f = ALU_SLL;
            3'b010: f = ALU_SLT;
            3'b011: f = ALU_SLTU;
            3'b100: f = ALU_XOR;
            3'b101: begin
                if (alt) f = ALU_SRA;
                else     f = ALU_SRL;
            end
            3'b110: f = ALU_OR;
            default: f = ALU_AND;
        endcase
        return f;
    endfunction

    assign opcode   = opcodeE'(instruction[6:0]);
    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    // branch condition from funct3
    always_comb begin
        case (funct3)
            3'b000:  branchTaken = eq;
            3'b001:  branchTaken = !eq;
            3'b100:  branchTaken = lt;
            3'b101:  branchTaken = !lt;
            3'b110:  branchTaken = ltu;
            3'b111:  branchTaken = !ltu;
            default: branchTaken = 1'b0;
        endcase
        if (opcode != OPC_BRANCH) branchTaken = 1'b0;
    end

    always_comb begin
        pcSel       = PC_PLUS4;
        op1Sel      = OP1_RS1;
        op2Sel      = OP2_RS2;
        wbSel       = WB_ALU;
        aluFunc     = ALU_ADD;
        regWrite    = 1'b0;
        memReq      = 1'b0;
        memWrite    = 1'b0;
        memUnsigned = funct3[2];
        imm         = '0;
        case (funct3[1:0])
            2'b00:   memWidth = MEM_BYTE;
            2'b01:   memWidth = MEM_HALF;
            default: memWidth = MEM_WORD;
        endcase

        case (opcode)
            OPC_OP: begin
                regWrite = 1'b1;
                aluFunc  = aluFromFunct(funct3, funct7b5, 1'b1);
            end
            OPC_OP_IMM: begin
                regWrite = 1'b1;
                op2Sel   = OP2_IMM;
                imm      = immI;
                aluFunc  = aluFromFunct(funct3, funct7b5, 1'b0);
            end
            OPC_LOAD: begin
                regWrite = 1'b1;
                op2Sel   = OP2_IMM;
                imm      = immI;
                wbSel    = WB_MEM;
                memReq   = 1'b1;
            end
            OPC_STORE: begin
                op2Sel   = OP2_IMM;
                imm      = immS;
                memReq   = 1'b1;
                memWrite = 1'b1;
            end
            OPC_BRANCH: begin
                // ALU only compares rs1 and rs2 here
                pcSel   = PC_BRANCH;
                imm     = immB;
                aluFunc = ALU_SUB;
            end
            OPC_JAL: begin
                pcSel    = PC_JAL;
                imm      = immJ;
                regWrite = 1'b1;
                wbSel    = WB_PC_PLUS4;
            end
            OPC_JALR: begin
                pcSel    = PC_JALR;
                op2Sel   = OP2_IMM;
                imm      = immI;
                regWrite = 1'b1;
                wbSel    = WB_PC_PLUS4;
            end
            OPC_LUI: begin
                op1Sel   = OP1_ZERO;
                op2Sel   = OP2_IMM;
                imm      = immU;
                aluFunc  = ALU_PASS_B;
                regWrite = 1'b1;
            end
            OPC_AUIPC: begin
                op1Sel   = OP1_PC;
                op2Sel   = OP2_IMM;
                imm      = immU;
                regWrite = 1'b1;
            end
            // unknown opcode behaves as a no-op
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/riscvIsaPkg.sv ====
`default_nettype none

package riscvIsaPkg;

    // major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } aluFuncE;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } memWidthE;

endpackage

`default_nettype wire

// ==== include/riscv_cfg.svh ====
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// data path width
`define RISCV_XLEN 32
`define RISCV_REG_COUNT 32
// address of the first fetched instruction
`define RISCV_RESET_PC 32'h0000_0000
// longest wait the memory model inserts before ack
`define RISCV_ACK_DELAY_MAX 3

`endif

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_riscvCore -f sources.f -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^test passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sources.f ====
+incdir+include
hdl/riscvIsaPkg.sv
hdl/riscvCtrlPkg.sv
hdl/memReqIf.sv
hdl/regFile.sv
hdl/alu.sv
hdl/riscvDecoder.sv
hdl/loadStoreUnit.sv
hdl/riscvDatapath.sv
hdl/riscvCore.sv
verification/tb_riscvCore.sv

// ==== verification/core_input.txt ====
// riscvCore vectors for $readmemh
// @000 program, four words per line, byte address of the first one in the comment
// @100 data memory words from byte address 0
// @200 store count, then one record per store: group (1 alu, 2 load, 3 lanes,
//      4 flow), wbAdr, wbSel, data on the selected lanes; stores to 0xfc must not occur
@000
12300093 FFB00113 002081B3 40208233 // 00 addi addi add sub
00409293 40115313 01C15393 00112433 // 10 slli srai srli slt
001134B3 ABCDE5B7 00001617 001156B3 // 20 sltu lui auipc srl
04302023 04402223 04502423 04602623 // 30 sw results
04702823 04802A23 04902C23 04B02E23 // 40 sw results
06C02023 06D02223 00100783 00104803 // 50 sw sw lb lbu
00201883 00205903 00002983 06F02423 // 60 lh lhu lw sw
07002623 07102823 07202A23 07302C23 // 70 sw loaded values
08100023 081000A3 08100123 081001A3 // 80 sb at offsets 0..3
08201223 08201323 00208463 00108463 // 90 sh sh beq beq
0E002E23 00109463 00209463 0E002E23 // a0 skipped bne bne skipped
0020C463 00114463 0E002E23 00115463 // b0 blt blt skipped bge
0020D463 0E002E23 00116463 0020E463 // c0 bge skipped bltu bltu
0E002E23 0020F463 00117463 0E002E23 // d0 skipped bgeu bgeu skipped
00800A6F 0E002E23 09402423 00000A97 // e0 jal skipped sw auipc
00DA8B67 0E002E23 09602623 0000006F // f0 jalr skipped sw loop
@100
F00D8A7E
@200
00000017
1 00000040 F 0000011E
1 00000044 F 00000128
1 00000048 F 00001230
1 0000004C F FFFFFFFD
1 00000050 F 0000000F
1 00000054 F 00000001
1 00000058 F 00000000
1 0000005C F ABCDE000
1 00000060 F 00001028
1 00000064 F 1FFFFFFF
2 00000068 F FFFFFF8A
2 0000006C F 0000008A
2 00000070 F FFFFF00D
2 00000074 F 0000F00D
2 00000078 F F00D8A7E
3 00000080 1 00000023
3 00000080 2 00002300
3 00000080 4 00230000
3 00000080 8 23000000
3 00000084 3 0000FFFB
3 00000084 C FFFB0000
4 00000088 F 000000E4
4 0000008C F 000000F4

// ==== verification/tb_riscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_cfg.svh"

module tb_riscvCore;

    localparam int ROM_WORDS     = 64;
    localparam int DMEM_WORDS    = 64;
    localparam int FILE_WORDS    = 1024;
    // word offsets of the sections in the input file
    localparam int DMEM_BASE     = 'h100;
    localparam int STORE_BASE    = 'h200;
    localparam int MAX_STORES    = 64;
    localparam int STORE_TIMEOUT = 2000;
    localparam int QUIET_CYCLES  = 20;

    logic        clk;
    logic        rstN;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic [31:0] wbDatOut;
    logic [3:0]  wbSel;
    logic [31:0] wbDatIn = '0;
    logic        wbAck = 1'b0;

    logic [31:0] fileMem [FILE_WORDS];
    logic [31:0] rom [ROM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] expGroup [MAX_STORES];
    logic [31:0] expAdr [MAX_STORES];
    logic [3:0]  expSel [MAX_STORES];
    logic [31:0] expDat [MAX_STORES];

    int storeCount;
    int errors;
    int checks;
    // owned by the memory model
    int          storesSeen = 0;
    int          slaveErrors = 0;
    int          storeChecks = 0;
    int          waitLeft = 0;
    logic        busy = 1'b0;
    logic [31:0] rngState = 32'h4de2;

    riscvCore u_dut (
        .clk(clk),
        .rstN(rstN),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatOut(wbDatOut),
        .wbSel(wbSel),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction ROM answers in the same cycle
    assign imemData = rom[imemAddr[7:2]];

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] laneMask(input logic [3:0] sel);
        logic [31:0] m;
        int i;
        for (i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{sel[i]}};
        end
        return m;
    endfunction

    function automatic string groupName(input logic [31:0] id);
        string s;
        case (id)
            32'd1:   s = "alu";
            32'd2:   s = "load extension";
            32'd3:   s = "store lanes";
            32'd4:   s = "control flow";
            default: s = "unknown group";
        endcase
        return s;
    endfunction

    // compare one completed store with the next expected record
    task automatic checkStore(input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
        logic [31:0] mask;
        string       name;
        if (storesSeen >= storeCount) begin
            $display("extra store to address %h beyond the expected list", adr);
            slaveErrors++;
        end else begin
            name = groupName(expGroup[storesSeen]);
            mask = laneMask(sel);
            storeChecks += 3;
            if (adr !== expAdr[storesSeen]) begin
                $display("[FAIL] %s store %0d address: expected %h, actual %h",
                         name, storesSeen, expAdr[storesSeen], adr);
                slaveErrors++;
            end
            if (sel !== expSel[storesSeen]) begin
                $display("[FAIL] %s store %0d sel: expected %h, actual %h",
                         name, storesSeen, expSel[storesSeen], sel);
                slaveErrors++;
            end
            if ((dat & mask) !== expDat[storesSeen]) begin
                $display("[FAIL] %s store %0d data: expected %h, actual %h",
                         name, storesSeen, expDat[storesSeen], dat & mask);
                slaveErrors++;
            end
        end
        storesSeen++;
    endtask

    task automatic mergeStore(input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
        int i;
        for (i = 0; i < 4; i++) begin
            if (sel[i]) begin
                dmem[adr[7:2]][8*i +: 8] = dat[8*i +: 8];
            end
        end
    endtask

    task automatic checkResetState(input string stage);
        checks += 3;
        if (wbCyc !== 1'b0) begin
            $display("[FAIL] reset %s wbCyc: expected 0, actual %b", stage, wbCyc);
            errors++;
        end
        if (wbStb !== 1'b0) begin
            $display("[FAIL] reset %s wbStb: expected 0, actual %b", stage, wbStb);
            errors++;
        end
        if (imemAddr !== `RISCV_RESET_PC) begin
            $display("[FAIL] reset %s pc: expected %h, actual %h",
                     stage, `RISCV_RESET_PC, imemAddr);
            errors++;
        end
    endtask

    // Wishbone slave memory with random wait states before each ack
    always @(negedge clk) begin : memoryModel
        int i;
        wbAck = 1'b0;
        if (!rstN) begin
            busy = 1'b0;
            for (i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] = fileMem[DMEM_BASE + i];
            end
        end else if (wbStb) begin
            if (!busy) begin
                rngState = nextRandom(rngState);
                waitLeft = rngState % (`RISCV_ACK_DELAY_MAX + 1);
                busy = 1'b1;
            end
            if (waitLeft == 0) begin
                busy = 1'b0;
                wbAck = 1'b1;
                if (wbWe) begin
                    checkStore(wbAdr, wbSel, wbDatOut);
                    mergeStore(wbAdr, wbSel, wbDatOut);
                end else begin
                    wbDatIn = dmem[wbAdr[7:2]];
                end
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

    initial begin
        int i;
        int cycles;
        rstN = 1'b0;
        errors = 0;
        checks = 0;
        // unloaded words carry their own index
        for (i = 0; i < FILE_WORDS; i++) begin
            fileMem[i] = 32'hA5A5_0000 ^ i;
        end
        $readmemh("verification/core_input.txt", fileMem);
        for (i = 0; i < ROM_WORDS; i++) begin
            rom[i] = fileMem[i];
        end
        storeCount = fileMem[STORE_BASE];
        if (storeCount < 1 || storeCount > MAX_STORES) begin
            $display("input file holds no usable store count (%0d)", storeCount);
            errors++;
            storeCount = 0;
        end
        for (i = 0; i < storeCount; i++) begin
            expGroup[i] = fileMem[STORE_BASE + 1 + 4 * i];
            expAdr[i]   = fileMem[STORE_BASE + 2 + 4 * i];
            expSel[i]   = fileMem[STORE_BASE + 3 + 4 * i][3:0];
            expDat[i]   = fileMem[STORE_BASE + 4 + 4 * i];
        end

        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            checkResetState("during reset");
        end
        rstN = 1'b1;
        checkResetState("at release");

        cycles = 0;
        while (storesSeen < storeCount && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (storesSeen < storeCount) begin
            $display("timeout after %0d cycles, only %0d of %0d stores seen",
                     cycles, storesSeen, storeCount);
            errors++;
        end

        // core should now sit in its final loop with the bus idle
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(negedge clk);
            if (wbCyc !== 1'b0) begin
                $display("unexpected bus cycle to address %h after the last store", wbAdr);
                errors++;
            end
            cycles++;
        end

        $display("errors %0d, checks %0d, stores %0d of %0d", errors + slaveErrors,
                 checks + storeChecks, storesSeen, storeCount);
        if (errors + slaveErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
